/* bench/bmac_patterns.hex */
// Columns: kind(1) op(1) data(4) lane(1) expected(10), all hex digits run together
// Kind 1 strobe, 2 check acc at lane, 3 end of test (data is test number), 4 idle cycle
// Test 1, accumulators read zero out of reset
20000000000000000
20000070000000000
200000F0000000000
30000100000000000
// Test 2, load lanes 0 to 15 then one mac with sample 1
12000300000000000
12000500000000000
12FFFE00000000000
12000700000000000
12010000000000000
12FFF900000000000
12000B00000000000
127FFF00000000000
12800000000000000
12000100000000000
12FF0000000000000
12001000000000000
12123400000000000
12FFFF00000000000
12004000000000000
12002500000000000
13000100000000000
20000000000000003
2000002FFFFFFFFFE
20000070000007FFF
2000008FFFFFF8000
200000C0000001234
200000F0000000025
30000200000000000
// Test 3, back to back macs, samples add up to 98 so each lane holds 99 times its coefficient
13000200000000000
13FFFD00000000000
13006400000000000
13800000000000000
137FFF00000000000
20000000000000129
2000005FFFFFFFD4B
20000070000317F9D
2000008FFFFCE8000
200000C0000070A1C
200000DFFFFFFFF9D
30000300000000000
// Test 4, clear then mac with sample 5
11000000000000000
13000500000000000
20000010000000019
20000040000000500
200000AFFFFFFFB00
200000F00000000B9
30000400000000000
// Test 5, partial load, clear, then loads restart at lane 0
12001100000000000
12002200000000000
12003300000000000
11000000000000000
12000900000000000
12FFFC00000000000
13000300000000000
2000000000000001B
2000001FFFFFFFFF4
20000020000000099
20000030000000015
30000500000000000
// Test 6, nop strobes and idle cycles leave the accumulators alone
10123400000000000
43010000000000000
41000000000000000
10FFFF00000000000
2000000000000001B
200000F000000006F
30000600000000000
00000000000000000

/* bench/bmac_sva.sv */
module bmac_sva #(
  parameter bit check_tree = 1'b1  // Tree latency checks when set, lane pulse checks when clear
) (
  input logic                                  clk,
  input logic                                  rst_n,
  input bmac_pkg::cmd_t                        cmd_in,
  input bmac_pkg::cmd_t [bmac_pkg::lanes-1:0] cmd_out,
  input logic                                  update
);

  logic copy0_acts;

  assign copy0_acts = (cmd_out[0].op == bmac_pkg::op_mac) ||
                      (cmd_out[0].op == bmac_pkg::op_clear);

  if (check_tree) begin : g_tree
    for (genvar k = 0; k < bmac_pkg::lanes; k++) begin : g_copy
      a_copy_delay: assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd_out[k] == $past(cmd_in, bmac_pkg::tree_depth)
      ) else $error("Tree copy %0d is not the command issued %0d cycles earlier",
                    k, bmac_pkg::tree_depth);
    end
  end else begin : g_lanes
    a_quiet_in_reset: assert property (
      @(posedge clk) !rst_n |-> !update
    ) else $error("acc_update is high while reset is asserted");

    // One pulse per op_mac or op_clear that reached copy 0
    a_update_pulse: assert property (
      @(posedge clk) disable iff (!rst_n)
      update == $past(copy0_acts)
    ) else $error("acc_update does not follow the op on copy 0 one cycle earlier");
  end

endmodule

bind fanout_tree bmac_sva #(.check_tree(1'b1)) u_sva (
  .clk     (clk),
  .rst_n   (rst_n),
  .cmd_in  (issue_cmd),
  .cmd_out (lane_cmd),
  .update  (1'b0)
);

bind mac_lanes bmac_sva #(.check_tree(1'b0)) u_sva (
  .clk     (clk),
  .rst_n   (rst_n),
  .cmd_in  (bmac_pkg::cmd_idle),
  .cmd_out (lane_cmd),
  .update  (acc_update)
);

/* bench/bmac_tb.sv */
module bmac_tb;

  localparam int acc_w       = 40;
  localparam int max_recs    = 256;
  localparam int half_period = 4;
  localparam int settle      = bmac_pkg::tree_depth + 2;  // Issue stage, tree, then accumulate

  localparam logic [3:0] kind_cmd   = 4'h1;
  localparam logic [3:0] kind_check = 4'h2;
  localparam logic [3:0] kind_end   = 4'h3;
  localparam logic [3:0] kind_gap   = 4'h4;

  // Each line of the pattern file holds 17 hex digits
  typedef struct packed {
    logic [3:0]                  kind;
    logic [3:0]                  op;
    logic [bmac_pkg::data_w-1:0] data;
    logic [bmac_pkg::lane_w-1:0] lane;
    logic [acc_w-1:0]            expected;
  } rec_t;

  logic                                         clk;
  logic                                         rst_n;
  logic                                         in_valid;
  bmac_pkg::op_e                                in_op;
  logic signed [bmac_pkg::data_w-1:0]           in_data;
  logic signed [bmac_pkg::lanes-1:0][acc_w-1:0] acc;
  logic                                         acc_update;

  logic [$bits(rec_t)-1:0] mem [0:max_recs-1];

  int cycles;
  int cycle_limit;
  int update_count;
  int exp_updates;
  int errors;
  int test_errors;
  int checks_done;
  int tests_passed;
  int tests_failed;

  bmac_top #(
    .ACC_WIDTH (acc_w)
  ) dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_data    (in_data),
    .acc        (acc),
    .acc_update (acc_update)
  );

  always #half_period clk = ~clk;

  always @(posedge clk) begin
    if (acc_update) begin
      update_count <= update_count + 1;
    end
  end

  initial begin
    @(posedge clk);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run timed out after %0d cycles without reaching the end of the patterns", cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic string test_name(input int id);
    case (id)
      1: return "reset_state";
      2: return "coef_load";
      3: return "mac_burst";
      4: return "clear_keeps_coef";
      5: return "clear_rewinds_pointer";
      6: return "idle_and_nop";
      default: return $sformatf("test_%0d", id);
    endcase
  endfunction

  task automatic check(input string name, input logic [acc_w-1:0] expected,
                       input logic [acc_w-1:0] actual);
    checks_done++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  initial begin
    rec_t          rec;
    bmac_pkg::op_e cmd_op;
    string         name;
    int            idx;
    int            lane;
    int            n_recs;
    int            n_checks;
    int            cur_test;
    bit            done;

    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_op    = bmac_pkg::op_nop;
    in_data  = '0;

    $readmemh("bench/bmac_patterns.hex", mem);

    // Records run up to the first line of unknown kind
    n_recs   = 0;
    n_checks = 0;
    done     = 1'b0;
    while (!done && n_recs < max_recs) begin
      rec = mem[n_recs];
      if (rec.kind == kind_cmd || rec.kind == kind_gap || rec.kind == kind_end) begin
        n_recs++;
      end else if (rec.kind == kind_check) begin
        n_recs++;
        n_checks++;
      end else begin
        done = 1'b1;
      end
    end
    cycle_limit = n_recs + settle * n_checks + 100;

    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // Every accumulator comes out of reset at zero
    for (lane = 0; lane < bmac_pkg::lanes; lane++) begin
      check($sformatf("%s lane %0d", test_name(1), lane), '0, acc[lane]);
    end

    cur_test = 1;
    for (idx = 0; idx < n_recs; idx++) begin
      rec  = mem[idx];
      name = test_name(cur_test);
      case (rec.kind)
        kind_cmd: begin
          cmd_op   = bmac_pkg::op_e'(rec.op[1:0]);
          in_valid = 1'b1;
          in_op    = cmd_op;
          in_data  = rec.data;
          if (cmd_op == bmac_pkg::op_mac || cmd_op == bmac_pkg::op_clear) begin
            exp_updates++;  // Each of these pulses acc_update once it lands
          end
          @(negedge clk);
        end
        kind_gap: begin  // Op and data sit on the bus while in_valid stays low
          in_valid = 1'b0;
          in_op    = bmac_pkg::op_e'(rec.op[1:0]);
          in_data  = rec.data;
          @(negedge clk);
        end
        kind_check: begin
          in_valid = 1'b0;
          in_op    = bmac_pkg::op_nop;
          in_data  = '0;
          repeat (settle) @(negedge clk);
          check($sformatf("%s lane %0d", name, rec.lane), rec.expected, acc[rec.lane]);
        end
        default: begin  // Every command before an end record has landed
          in_valid = 1'b0;
          check($sformatf("%s acc_update count", name), acc_w'(exp_updates),
                acc_w'(update_count));
          if (int'(rec.data) != cur_test) begin
            errors++;
            test_errors++;
            $display("Pattern file closes test %0d where test %0d was expected",
                     rec.data, cur_test);
          end
          if (test_errors == 0) begin
            tests_passed++;
            $display("%s: PASS", name);
          end else begin
            tests_failed++;
            $display("%s: FAIL", name);
          end
          test_errors = 0;
          cur_test++;
        end
      endcase
    end

    $display("Summary: %0d tests passed, %0d failed, %0d checks, %0d mismatches",
             tests_passed, tests_failed, checks_done, errors);
    if (errors == 0 && tests_failed == 0 && tests_passed > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      if (tests_passed + tests_failed == 0) begin
        $display("No test records were read from the pattern file");
      end
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* rtl/bmac_pkg.sv */
package bmac_pkg;

  localparam int data_w = 16;  // Sample and coefficient width

  localparam int lanes = 16;  // Accumulator lanes fed by the tree

  localparam int lane_w = $clog2(lanes);

  localparam int tree_depth = 4;  // Register stages from issue_cmd to lane_cmd

  typedef enum logic [1:0] {
    op_nop   = 2'd0,  // Idle value held by every pipeline stage
    op_clear = 2'd1,  // Zero all accumulators and rewind the load pointer
    op_load  = 2'd2,  // Write one coefficient at the load pointer
    op_mac   = 2'd3   // Every lane adds coefficient times sample
  } op_e;

  // One command as it moves down the tree, 22 bits wide
  typedef struct packed {
    op_e                      op;
    logic [lane_w-1:0]        lane;  // Target lane, only meaningful for op_load
    logic signed [data_w-1:0] data;  // Sample for op_mac, coefficient for op_load
  } cmd_t;

  localparam cmd_t cmd_idle = '{
    op:   op_nop,
    lane: '0,
    data: '0
  };

endpackage

/* rtl/bmac_top.sv */
module bmac_top #(
  parameter int ACC_WIDTH = 40  // Any value of 32 or more
) (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              in_valid,
  input  bmac_pkg::op_e                                     in_op,
  input  logic signed [bmac_pkg::data_w-1:0]                in_data,
  output logic signed [bmac_pkg::lanes-1:0][ACC_WIDTH-1:0] acc,
  output logic                                              acc_update
);

  bmac_pkg::cmd_t                        issue_cmd;
  bmac_pkg::cmd_t [bmac_pkg::lanes-1:0] lane_cmd;  // Copy k feeds lane k

  // One cycle from strobe to command
  cmd_issue u_issue (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .in_data   (in_data),
    .issue_cmd (issue_cmd)
  );

  // Four more cycles to reach every lane
  fanout_tree u_tree (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue_cmd (issue_cmd),
    .lane_cmd  (lane_cmd)
  );

  mac_lanes #(
    .ACC_WIDTH (ACC_WIDTH)
  ) u_lanes (
    .clk        (clk),
    .rst_n      (rst_n),
    .lane_cmd   (lane_cmd),
    .acc        (acc),
    .acc_update (acc_update)
  );

endmodule

/* rtl/cmd_issue.sv */
module cmd_issue (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               in_valid,
  input  bmac_pkg::op_e                      in_op,
  input  logic signed [bmac_pkg::data_w-1:0] in_data,
  output bmac_pkg::cmd_t                     issue_cmd
);

  logic [bmac_pkg::lane_w-1:0] load_ptr;  // Lane that the next op_load writes
  logic                        take;

  assign take = in_valid && (in_op != bmac_pkg::op_nop);  // A strobe carrying op_nop is dropped

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_cmd <= bmac_pkg::cmd_idle;
    end else if (take) begin
      issue_cmd.op   <= in_op;
      issue_cmd.data <= in_data;
      if (in_op == bmac_pkg::op_load) begin
        issue_cmd.lane <= load_ptr;
      end else begin
        issue_cmd.lane <= '0;
      end
    end else begin
      issue_cmd <= bmac_pkg::cmd_idle;  // Idle cycles become op_nop bubbles
    end
  end

  // Sixteen plain op_load strobes fill lanes 0 to 15 in order
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_ptr <= '0;
    end else if (take) begin
      case (in_op)
        bmac_pkg::op_load: begin
          load_ptr <= load_ptr + 1'b1;  // Wraps back to lane 0 after lane 15
        end
        bmac_pkg::op_clear: begin
          load_ptr <= '0;
        end
        default: begin
          load_ptr <= load_ptr;
        end
      endcase
    end
  end

endmodule

/* rtl/fanout_tree.sv */
module fanout_tree (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  bmac_pkg::cmd_t                        issue_cmd,
  output bmac_pkg::cmd_t [bmac_pkg::lanes-1:0] lane_cmd
);

  localparam int fan = 4;  // Branching factor of each tree level
  localparam int mid = bmac_pkg::lanes / fan;

  bmac_pkg::cmd_t                        r0;  // Stage 1, drives four loads
  bmac_pkg::cmd_t [mid-1:0]              r1;  // Stage 2, each drives four loads
  bmac_pkg::cmd_t [bmac_pkg::lanes-1:0] r2;
  bmac_pkg::cmd_t [bmac_pkg::lanes-1:0] r3;  // Stage 4, one register per lane

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r0 <= bmac_pkg::cmd_idle;
    end else begin
      r0 <= issue_cmd;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < mid; i++) begin
        r1[i] <= bmac_pkg::cmd_idle;
      end
    end else begin
      for (int i = 0; i < mid; i++) begin
        r1[i] <= r0;
      end
    end
  end

  // Lane k hangs off branch k / fan of stage 2
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < bmac_pkg::lanes; k++) begin
        r2[k] <= bmac_pkg::cmd_idle;
      end
    end else begin
      for (int k = 0; k < bmac_pkg::lanes; k++) begin
        r2[k] <= r1[k / fan];
      end
    end
  end

  // The last stage is one to one and keeps every leaf close to its lane
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < bmac_pkg::lanes; k++) begin
        r3[k] <= bmac_pkg::cmd_idle;
      end
    end else begin
      for (int k = 0; k < bmac_pkg::lanes; k++) begin
        r3[k] <= r2[k];
      end
    end
  end

  assign lane_cmd = r3;

endmodule

/* rtl/mac_lanes.sv */
module mac_lanes #(
  parameter int ACC_WIDTH = 40
) (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  bmac_pkg::cmd_t [bmac_pkg::lanes-1:0]               lane_cmd,
  output logic signed [bmac_pkg::lanes-1:0][ACC_WIDTH-1:0]   acc,
  output logic                                                acc_update
);

  localparam int prod_w = 2 * bmac_pkg::data_w;

  for (genvar k = 0; k < bmac_pkg::lanes; k++) begin : g_lane
    bmac_pkg::cmd_t                     cmd;
    logic signed [bmac_pkg::data_w-1:0] coef;
    logic signed [prod_w-1:0]           prod;
    logic signed [ACC_WIDTH-1:0]        prod_ext;
    logic signed [ACC_WIDTH-1:0]        acc_q;
    logic                               hit;

    assign cmd = lane_cmd[k];
    assign hit = (cmd.lane == bmac_pkg::lane_w'(k));  // This copy addresses lane k

    assign prod     = coef * cmd.data;
    assign prod_ext = prod;  // Sign extends, ACC_WIDTH is never below prod_w

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        coef <= '0;
      end else if (cmd.op == bmac_pkg::op_load && hit) begin
        coef <= cmd.data;
      end
    end

    // Coefficients survive op_clear
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        acc_q <= '0;
      end else begin
        case (cmd.op)
          bmac_pkg::op_clear: begin
            acc_q <= '0;
          end
          bmac_pkg::op_mac: begin
            acc_q <= acc_q + prod_ext;  // Wraps silently at ACC_WIDTH bits
          end
          default: begin
            acc_q <= acc_q;
          end
        endcase
      end
    end

    assign acc[k] = acc_q;
  end

  // Copy 0 arrives together with all other copies, so it stands for the whole array
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_update <= 1'b0;
    end else begin
      acc_update <= (lane_cmd[0].op == bmac_pkg::op_mac) ||
                    (lane_cmd[0].op == bmac_pkg::op_clear);
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the broadcast MAC testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module bmac_tb \
  -f verilog.f \
  -o bmac_sim

# A failed assertion stops the simulator with a non-zero status, so the log decides
./obj_dir/bmac_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

/* verilog.f */
rtl/bmac_pkg.sv
rtl/cmd_issue.sv
rtl/fanout_tree.sv
rtl/mac_lanes.sv
rtl/bmac_top.sv
bench/bmac_sva.sv
bench/bmac_tb.sv
